/* source/nice_pkg.sv */
// shared definitions for the custom3 row buffer coprocessor
// widths, instruction codes, operation and state encodings
package nice_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // data path
   ////////////////////////////////////////////////////////////////////////////
   // data and address width
   localparam int word_w = 32;

   typedef logic [word_w-1:0] word_t;

   // address step between row words
   localparam word_t word_bytes = 32'd4;

   // icb size code of a full word access
   localparam logic [1:0] size_word = 2'b10;

   ////////////////////////////////////////////////////////////////////////////
   // instruction codes, R type only
   ////////////////////////////////////////////////////////////////////////////
   localparam logic [6:0] opcode_custom3 = 7'b1111011;

   // lbuf and sbuf share one minor code
   localparam logic [2:0] funct3_buf    = 3'b010;
   localparam logic [2:0] funct3_rowsum = 3'b110;

   localparam logic [6:0] funct7_lbuf   = 7'b0000001;
   localparam logic [6:0] funct7_sbuf   = 7'b0000010;
   localparam logic [6:0] funct7_rowsum = 7'b0000110;

   // decoded operation, op_none for anything not supported
   typedef enum logic [1:0] {
      op_none,
      op_lbuf,
      op_sbuf,
      op_rowsum
   } op_t;

   // sequencer states
   typedef enum logic [2:0] {
      st_idle,
      st_load,
      st_store,
      st_rowsum,
      st_respond
   } state_t;

endpackage

/* source/nice_rowbuf_if.sv */
// row buffer traffic between the memory unit and the row buffer
`timescale 1ns/1ps

interface nice_rowbuf_if #(
   parameter int rowbuf_depth = 4
);
   localparam int idx_w = $clog2(rowbuf_depth);

   // lbuf writes straight from the memory response
   logic                  wr_en;
   logic [idx_w-1:0]      wr_idx;
   nice_pkg::word_t       wr_data;

   // rowsum column accumulation from the capture register
   logic                  acc_en;
   logic [idx_w-1:0]      acc_idx;
   nice_pkg::word_t       acc_data;

   // sbuf read port
   logic [idx_w-1:0]      rd_idx;
   nice_pkg::word_t       rd_data;

   nice_pkg::word_t       row_sum;
   // last beat accumulated, single cycle
   logic                  acc_done;

   modport lsu (
      output wr_en, wr_idx, wr_data, acc_en, acc_idx, acc_data, rd_idx,
      input  rd_data, row_sum, acc_done
   );

   modport rowbuf (
      input  wr_en, wr_idx, wr_data, acc_en, acc_idx, acc_data, rd_idx,
      output rd_data, row_sum, acc_done
   );

endinterface

/* source/nice_ctrl_fsm.sv */
// coprocessor sequencer: decodes custom3 requests, steps through
// load, store and row-sum, and holds the response until it is taken
`timescale 1ns/1ps

module nice_ctrl_fsm (
   input  logic              nice_clk,
   input  logic              reset,
   input  logic              req_valid,
   input  nice_pkg::word_t   req_inst,
   output logic              req_ready,
   input  logic              icb_cmd_ready,
   input  logic              rsp_ready,
   input  logic              rsp_last,
   input  logic              acc_done,
   input  logic              bus_err,
   output logic              start,
   output nice_pkg::op_t     op,
   output nice_pkg::state_t  state,
   output logic              rsp_valid,
   output logic              rsp_err,
   output logic              active,
   output logic              mem_holdup
);

   nice_pkg::op_t    op_dec;
   nice_pkg::op_t    op_r;
   nice_pkg::state_t state_nxt;
   logic             is_idle;

   ////////////////////////////////////////////////////////////////////////////
   // decode
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      op_dec = nice_pkg::op_none;
      if (req_inst[6:0] == nice_pkg::opcode_custom3) begin
         if (req_inst[14:12] == nice_pkg::funct3_buf &&
             req_inst[31:25] == nice_pkg::funct7_lbuf) begin
            op_dec = nice_pkg::op_lbuf;
         end else if (req_inst[14:12] == nice_pkg::funct3_buf &&
                      req_inst[31:25] == nice_pkg::funct7_sbuf) begin
            op_dec = nice_pkg::op_sbuf;
         end else if (req_inst[14:12] == nice_pkg::funct3_rowsum &&
                      req_inst[31:25] == nice_pkg::funct7_rowsum) begin
            op_dec = nice_pkg::op_rowsum;
         end
      end
   end

   assign is_idle = (state == nice_pkg::st_idle);

   // every kept op issues its first command with the request
   assign req_ready = is_idle & ((op_dec == nice_pkg::op_none) | icb_cmd_ready);
   // unsupported requests are taken but never start anything
   assign start     = req_valid & req_ready & (op_dec != nice_pkg::op_none);

   // live decode while idle, held copy for the rest of the op
   assign op = is_idle ? op_dec : op_r;

   ////////////////////////////////////////////////////////////////////////////
   // state sequence
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      state_nxt = state;
      case (state)
         nice_pkg::st_idle: begin
            if (start) begin
               case (op_dec)
                  nice_pkg::op_lbuf: state_nxt = nice_pkg::st_load;
                  nice_pkg::op_sbuf: state_nxt = nice_pkg::st_store;
                  default:           state_nxt = nice_pkg::st_rowsum;
               endcase
            end
         end
         nice_pkg::st_load,
         nice_pkg::st_store: begin
            if (rsp_last) state_nxt = nice_pkg::st_respond;
         end
         // waits for capture and accumulate of the last word
         nice_pkg::st_rowsum: begin
            if (acc_done) state_nxt = nice_pkg::st_respond;
         end
         nice_pkg::st_respond: begin
            if (rsp_ready) state_nxt = nice_pkg::st_idle;
         end
         default: state_nxt = nice_pkg::st_idle;
      endcase
   end

   always_ff @(posedge nice_clk) begin
      if (reset) begin
         state <= nice_pkg::st_idle;
         op_r  <= nice_pkg::op_none;
      end else begin
         state <= state_nxt;
         if (start) op_r <= op_dec;
      end
   end

   // response and status
   assign rsp_valid  = (state == nice_pkg::st_respond);
   assign rsp_err    = rsp_valid & bus_err;
   assign active     = is_idle ? req_valid : 1'b1;
   assign mem_holdup = ~is_idle;

   // response and its error flag must not change before the core takes it
   rsp_hold_a : assert property (
      @(posedge nice_clk) disable iff (reset)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_err)
   );

endmodule

/* source/nice_beat_counter.sv */
// per-row beat counting of issued memory commands and returned responses
`timescale 1ns/1ps

module nice_beat_counter #(
   parameter int row_len      = 3,
   parameter int rowbuf_depth = 4
) (
   input  logic                                   nice_clk,
   input  logic                                   reset,
   input  logic                                   start,
   input  logic                                   cmd_fire,
   input  logic                                   rsp_fire,
   output logic [$clog2(rowbuf_depth+1)-1:0]      cmd_cnt,
   output logic [$clog2(rowbuf_depth+1)-1:0]      rsp_cnt,
   output logic                                   cmd_full,
   output logic                                   rsp_last
);

   // counts run 0 to row_len inclusive
   localparam int cnt_w = $clog2(rowbuf_depth + 1);

   always_ff @(posedge nice_clk) begin
      if (reset) begin
         cmd_cnt <= '0;
         rsp_cnt <= '0;
      end else if (start) begin
         // first command leaves together with the request
         cmd_cnt <= cnt_w'(cmd_fire);
         rsp_cnt <= '0;
      end else begin
         cmd_cnt <= cmd_cnt + cnt_w'(cmd_fire);
         rsp_cnt <= rsp_cnt + cnt_w'(rsp_fire);
      end
   end

   // stop issuing once the whole row is out
   assign cmd_full = (cmd_cnt == cnt_w'(row_len));

   // handshake of the final response of the row
   assign rsp_last = rsp_fire & (rsp_cnt == cnt_w'(row_len - 1));

   // a response only ever answers a command already issued
   rsp_after_cmd_a : assert property (
      @(posedge nice_clk) disable iff (reset)
      rsp_fire |-> rsp_cnt < cmd_cnt
   );

endmodule

/* source/nice_lsu.sv */
// memory unit: icb command issue with address stepping, store data
// select, lbuf write path, rowsum capture and sticky bus error
`timescale 1ns/1ps

module nice_lsu #(
   parameter int rowbuf_depth = 4
) (
   input  logic                                   nice_clk,
   input  logic                                   reset,
   input  logic                                   req_valid,
   input  nice_pkg::word_t                        req_rs1,
   input  logic                                   start,
   input  nice_pkg::op_t                          op,
   input  nice_pkg::state_t                       state,
   input  logic [$clog2(rowbuf_depth+1)-1:0]      cmd_cnt,
   input  logic [$clog2(rowbuf_depth+1)-1:0]      rsp_cnt,
   input  logic                                   cmd_full,
   output logic                                   icb_cmd_valid,
   input  logic                                   icb_cmd_ready,
   output nice_pkg::word_t                        icb_cmd_addr,
   output logic                                   icb_cmd_read,
   output nice_pkg::word_t                        icb_cmd_wdata,
   input  logic                                   icb_rsp_valid,
   output logic                                   icb_rsp_ready,
   input  nice_pkg::word_t                        icb_rsp_rdata,
   input  logic                                   icb_rsp_err,
   output logic                                   cmd_fire,
   output logic                                   rsp_fire,
   output logic                                   bus_err,
   nice_rowbuf_if.lsu                             rb
);

   localparam int idx_w = $clog2(rowbuf_depth);

   logic              is_idle;
   logic              busy;
   nice_pkg::word_t   addr_r;
   logic              cap_valid;
   nice_pkg::word_t   cap_data;
   logic [idx_w-1:0]  cap_idx;

   assign is_idle = (state == nice_pkg::st_idle);
   assign busy    = (state == nice_pkg::st_load) |
                    (state == nice_pkg::st_store) |
                    (state == nice_pkg::st_rowsum);

   ////////////////////////////////////////////////////////////////////////////
   // command side
   ////////////////////////////////////////////////////////////////////////////
   // idle: first beat rides on the request; busy: keep going until full
   assign icb_cmd_valid = (is_idle & req_valid & (op != nice_pkg::op_none)) |
                          (busy & ~cmd_full);
   assign cmd_fire      = icb_cmd_valid & icb_cmd_ready;

   assign icb_cmd_addr  = is_idle ? req_rs1 : addr_r;
   // only sbuf writes
   assign icb_cmd_read  = (op != nice_pkg::op_sbuf);

   // store index starts at 0 with the request beat
   assign rb.rd_idx     = is_idle ? '0 : cmd_cnt[idx_w-1:0];
   assign icb_cmd_wdata = rb.rd_data;

   // next word address after every accepted command
   always_ff @(posedge nice_clk) begin
      if (cmd_fire) addr_r <= icb_cmd_addr + nice_pkg::word_bytes;
   end

   ////////////////////////////////////////////////////////////////////////////
   // response side
   ////////////////////////////////////////////////////////////////////////////
   // no back-pressure toward memory
   assign icb_rsp_ready = 1'b1;
   assign rsp_fire      = icb_rsp_valid & icb_rsp_ready;

   // lbuf: read data goes straight into the row buffer
   assign rb.wr_en   = rsp_fire & (state == nice_pkg::st_load);
   assign rb.wr_idx  = rsp_cnt[idx_w-1:0];
   assign rb.wr_data = icb_rsp_rdata;

   // rowsum: register the word so the adders start from a flop
   always_ff @(posedge nice_clk) begin
      if (reset) begin
         cap_valid <= 1'b0;
      end else begin
         cap_valid <= rsp_fire & (state == nice_pkg::st_rowsum);
      end
   end

   always_ff @(posedge nice_clk) begin
      if (rsp_fire) begin
         cap_data <= icb_rsp_rdata;
         cap_idx  <= rsp_cnt[idx_w-1:0];
      end
   end

   assign rb.acc_en   = cap_valid;
   assign rb.acc_idx  = cap_idx;
   assign rb.acc_data = cap_data;

   // sticky bus error, cleared by the next op
   always_ff @(posedge nice_clk) begin
      if (reset) begin
         bus_err <= 1'b0;
      end else if (start) begin
         bus_err <= 1'b0;
      end else if (rsp_fire & icb_rsp_err) begin
         bus_err <= 1'b1;
      end
   end

endmodule

/* source/nice_rowbuf.sv */
// row buffer registers with per-column accumulation and the row-sum
// accumulator used by rowsum
`timescale 1ns/1ps

module nice_rowbuf #(
   parameter int row_len      = 3,
   parameter int rowbuf_depth = 4
) (
   input  logic           nice_clk,
   input  logic           reset,
   nice_rowbuf_if.rowbuf  rb
);

   localparam int idx_w = $clog2(rowbuf_depth);

   nice_pkg::word_t entry [rowbuf_depth];
   nice_pkg::word_t sum_r;

   ////////////////////////////////////////////////////////////////////////////
   // entries
   ////////////////////////////////////////////////////////////////////////////
   // lbuf overwrites, rowsum adds the captured word into its column
   always_ff @(posedge nice_clk) begin
      if (reset) begin
         for (int i = 0; i < rowbuf_depth; i++) begin
            entry[i] <= '0;
         end
      end else if (rb.wr_en) begin
         entry[rb.wr_idx] <= rb.wr_data;
      end else if (rb.acc_en) begin
         entry[rb.acc_idx] <= entry[rb.acc_idx] + rb.acc_data;
      end
   end

   // sbuf read
   assign rb.rd_data = entry[rb.rd_idx];

   ////////////////////////////////////////////////////////////////////////////
   // row sum
   ////////////////////////////////////////////////////////////////////////////
   // word 0 restarts the sum, later words add on, wraps mod 2^32
   always_ff @(posedge nice_clk) begin
      if (reset) begin
         sum_r <= '0;
      end else if (rb.acc_en) begin
         if (rb.acc_idx == '0) begin
            sum_r <= rb.acc_data;
         end else begin
            sum_r <= sum_r + rb.acc_data;
         end
      end
   end

   assign rb.row_sum  = sum_r;

   // final column goes in at this edge, sum is complete next cycle
   assign rb.acc_done = rb.acc_en & (rb.acc_idx == idx_w'(row_len - 1));

   // lbuf and rowsum never overlap, so the two write paths are exclusive
   wr_acc_excl_a : assert property (
      @(posedge nice_clk) disable iff (reset)
      !(rb.wr_en && rb.acc_en)
   );

endmodule

/* source/nice_core.sv */
// custom3 coprocessor top: lbuf, sbuf and rowsum over a request and
// response port with an icb memory port
`timescale 1ns/1ps

module nice_core #(
   parameter int row_len      = 3,
   parameter int rowbuf_depth = 4
) (
   input  logic             nice_clk,
   input  logic             reset,
   output logic             active,
   output logic             mem_holdup,
   // request from the core
   input  logic             req_valid,
   output logic             req_ready,
   input  nice_pkg::word_t  req_inst,
   input  nice_pkg::word_t  req_rs1,
   // rs2 is not read by any of the kept instructions
   input  nice_pkg::word_t  req_rs2,
   // response to the core
   output logic             rsp_valid,
   input  logic             rsp_ready,
   output nice_pkg::word_t  rsp_rdat,
   output logic             rsp_err,
   // icb command
   output logic             icb_cmd_valid,
   input  logic             icb_cmd_ready,
   output nice_pkg::word_t  icb_cmd_addr,
   output logic             icb_cmd_read,
   output nice_pkg::word_t  icb_cmd_wdata,
   output logic [1:0]       icb_cmd_size,
   // icb response
   input  logic             icb_rsp_valid,
   output logic             icb_rsp_ready,
   input  nice_pkg::word_t  icb_rsp_rdata,
   input  logic             icb_rsp_err
);

   localparam int cnt_w = $clog2(rowbuf_depth + 1);

   logic              start;
   nice_pkg::op_t     op;
   nice_pkg::state_t  state;
   logic [cnt_w-1:0]  cmd_cnt;
   logic [cnt_w-1:0]  rsp_cnt;
   logic              cmd_full;
   logic              rsp_last;
   logic              cmd_fire;
   logic              rsp_fire;
   logic              bus_err;

   nice_rowbuf_if #(.rowbuf_depth(rowbuf_depth)) rb_if ();

   nice_ctrl_fsm ctrl_inst (
      .nice_clk, .reset, .req_valid, .req_inst, .req_ready, .icb_cmd_ready,
      .rsp_ready, .rsp_last, .acc_done(rb_if.acc_done), .bus_err, .start,
      .op, .state, .rsp_valid, .rsp_err, .active, .mem_holdup
   );

   nice_beat_counter #(.row_len(row_len), .rowbuf_depth(rowbuf_depth)) beat_inst (
      .nice_clk, .reset, .start, .cmd_fire, .rsp_fire,
      .cmd_cnt, .rsp_cnt, .cmd_full, .rsp_last
   );

   nice_lsu #(.rowbuf_depth(rowbuf_depth)) lsu_inst (
      .nice_clk, .reset, .req_valid, .req_rs1, .start, .op, .state,
      .cmd_cnt, .rsp_cnt, .cmd_full, .icb_cmd_valid, .icb_cmd_ready,
      .icb_cmd_addr, .icb_cmd_read, .icb_cmd_wdata, .icb_rsp_valid,
      .icb_rsp_ready, .icb_rsp_rdata, .icb_rsp_err, .cmd_fire, .rsp_fire,
      .bus_err, .rb(rb_if.lsu)
   );

   nice_rowbuf #(.row_len(row_len), .rowbuf_depth(rowbuf_depth)) rowbuf_inst (
      .nice_clk, .reset, .rb(rb_if.rowbuf)
   );

   // only rowsum returns a value in rd
   assign rsp_rdat     = (op == nice_pkg::op_rowsum) ? rb_if.row_sum : '0;
   assign icb_cmd_size = nice_pkg::size_word;

endmodule

/* verif/nice_mem_model.sv */
// icb word memory for the testbench: in-order responses after a random
// latency of 0 to 3 cycles, error flag returned for one address
`timescale 1ns/1ps

module nice_mem_model #(
   parameter nice_pkg::word_t err_addr = 32'h0000_0304
) (
   input  logic             nice_clk,
   input  logic             reset,
   input  logic             cmd_valid,
   output logic             cmd_ready,
   input  nice_pkg::word_t  cmd_addr,
   input  logic             cmd_read,
   input  nice_pkg::word_t  cmd_wdata,
   output logic             rsp_valid,
   input  logic             rsp_ready,
   output nice_pkg::word_t  rsp_rdata,
   output logic             rsp_err
);

   // 256 words, byte addresses 0 to 1023
   nice_pkg::word_t mem [256];

   // pending responses, oldest first
   nice_pkg::word_t q_data [$];
   logic            q_err [$];
   int              q_due [$];

   logic [31:0]     lcg_state;
   int              cyc;
   int              due;
   int              last_due;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // pattern spreads every address bit over the word
   function automatic nice_pkg::word_t fill_word(input nice_pkg::word_t addr);
      return (addr * 32'h9e37_79b9) ^ 32'h5a3c_0f17;
   endfunction

   initial begin
      for (int i = 0; i < 256; i++) begin
         mem[i] = fill_word(nice_pkg::word_t'(i) * 4);
      end
   end

   // commands never stall
   assign cmd_ready = 1'b1;

   always @(posedge nice_clk) begin
      if (reset) begin
         q_data.delete();
         q_err.delete();
         q_due.delete();
         lcg_state = 32'h1cd0_2130;
         cyc       = 0;
         last_due  = 0;
         rsp_valid <= 1'b0;
         rsp_rdata <= '0;
         rsp_err   <= 1'b0;
      end else begin
         // response taken at this edge
         if (rsp_valid && rsp_ready) begin
            void'(q_data.pop_front());
            void'(q_err.pop_front());
            void'(q_due.pop_front());
         end
         if (cmd_valid && cmd_ready) begin
            lcg_state = lcg_next(lcg_state);
            due = cyc + int'(lcg_state[17:16]);
            // keep responses in order
            if (due < last_due) due = last_due;
            last_due = due;
            q_err.push_back(cmd_addr == err_addr);
            q_due.push_back(due);
            if (cmd_read) begin
               q_data.push_back(mem[cmd_addr[9:2]]);
            end else begin
               mem[cmd_addr[9:2]] = cmd_wdata;
               q_data.push_back('0);
            end
         end
         // present the oldest response once its latency is over
         if (q_due.size() > 0 && q_due[0] <= cyc) begin
            rsp_valid <= 1'b1;
            rsp_rdata <= q_data[0];
            rsp_err   <= q_err[0];
         end else begin
            rsp_valid <= 1'b0;
         end
         cyc++;
      end
   end

endmodule

/* verif/nice_core_tb.sv */
// testbench for the custom3 coprocessor: directed lbuf, sbuf and rowsum
// tests against the icb memory model
`timescale 1ns/1ps

module nice_core_tb;

   localparam int              row_len    = 3;
   localparam nice_pkg::word_t err_addr   = 32'h0000_0304;
   // 6 tests x 40 cycles plus reset, rounded up
   localparam int              max_cycles = 400;

   logic             nice_clk;
   logic             reset;
   logic             active;
   logic             mem_holdup;
   logic             req_valid;
   logic             req_ready;
   nice_pkg::word_t  req_inst;
   nice_pkg::word_t  req_rs1;
   nice_pkg::word_t  req_rs2;
   logic             rsp_valid;
   logic             rsp_ready;
   nice_pkg::word_t  rsp_rdat;
   logic             rsp_err;
   logic             icb_cmd_valid;
   logic             icb_cmd_ready;
   nice_pkg::word_t  icb_cmd_addr;
   logic             icb_cmd_read;
   nice_pkg::word_t  icb_cmd_wdata;
   logic [1:0]       icb_cmd_size;
   logic             icb_rsp_valid;
   logic             icb_rsp_ready;
   nice_pkg::word_t  icb_rsp_rdata;
   logic             icb_rsp_err;

   int               cycle_cnt;
   int               checks;
   int               test_errors;
   int               total_errors;
   int               tests_run;
   int               tests_failed;
   string            cur_test;

   // every accepted icb command, in order
   nice_pkg::word_t  mon_addr [$];
   logic             mon_read [$];
   logic [1:0]       mon_size [$];
   int               mon_count;

   nice_core #(.row_len(row_len), .rowbuf_depth(4)) nice_core_inst (.*);

   nice_mem_model #(.err_addr(err_addr)) mem_inst (
      .nice_clk, .reset, .cmd_valid(icb_cmd_valid), .cmd_ready(icb_cmd_ready),
      .cmd_addr(icb_cmd_addr), .cmd_read(icb_cmd_read), .cmd_wdata(icb_cmd_wdata),
      .rsp_valid(icb_rsp_valid), .rsp_ready(icb_rsp_ready),
      .rsp_rdata(icb_rsp_rdata), .rsp_err(icb_rsp_err)
   );

   initial begin
      nice_clk = 1'b0;
      forever #10 nice_clk = ~nice_clk;
   end

   // watchdog
   always @(posedge nice_clk) begin
      cycle_cnt++;
      if (cycle_cnt >= max_cycles) begin
         $display("timeout: tests did not finish within %0d cycles", max_cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   // command monitor, sampled before the edge updates anything
   always @(posedge nice_clk) begin
      if (!reset && icb_cmd_valid && icb_cmd_ready) begin
         mon_addr.push_back(icb_cmd_addr);
         mon_read.push_back(icb_cmd_read);
         mon_size.push_back(icb_cmd_size);
         mon_count++;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////
   // R type custom3 word, register fields are don't care
   function automatic nice_pkg::word_t make_inst(input logic [6:0] funct7,
                                                 input logic [2:0] funct3);
      return {funct7, 5'd2, 5'd1, funct3, 5'd10, nice_pkg::opcode_custom3};
   endfunction

   function automatic nice_pkg::word_t mem_word(input nice_pkg::word_t addr);
      return mem_inst.mem[addr[9:2]];
   endfunction

   task automatic check_word(input string what, input nice_pkg::word_t exp,
                             input nice_pkg::word_t act);
      checks++;
      if (act !== exp) begin
         test_errors++;
         $display("error %s %s: expected %h, actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         test_errors++;
         $display("error %s %s: expected %b, actual %b", cur_test, what, exp, act);
      end
   endtask

   task automatic begin_test(input string name);
      cur_test    = name;
      test_errors = 0;
      tests_run++;
   endtask

   task automatic end_test();
      total_errors += test_errors;
      if (test_errors != 0) tests_failed++;
      $display("%s: %0d errors", cur_test, test_errors);
   endtask

   // one request through to its response; hold > 0 stalls rsp_ready
   task automatic run_op(input nice_pkg::word_t inst, input nice_pkg::word_t rs1,
                         input int hold, output nice_pkg::word_t rdat,
                         output logic err);
      nice_pkg::word_t first_rdat;
      req_inst  = inst;
      req_rs1   = rs1;
      req_valid = 1'b1;
      rsp_ready = (hold == 0);
      do @(posedge nice_clk); while (!req_ready);
      #2 req_valid = 1'b0;
      do @(posedge nice_clk); while (!rsp_valid);
      first_rdat = rsp_rdat;
      if (hold > 0) begin
         repeat (hold) begin
            @(posedge nice_clk);
            check_bit("rsp_valid held", 1'b1, rsp_valid);
            check_word("rsp_rdat held", first_rdat, rsp_rdat);
            check_bit("mem_holdup held", 1'b1, mem_holdup);
            check_bit("active held", 1'b1, active);
            check_bit("req_ready held", 1'b0, req_ready);
         end
         #2 rsp_ready = 1'b1;
         @(posedge nice_clk);
         check_bit("rsp_valid at handshake", 1'b1, rsp_valid);
      end
      rdat = rsp_rdat;
      err  = rsp_err;
      #2;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////////////////////
   task automatic test_round_trip();
      nice_pkg::word_t src [row_len];
      nice_pkg::word_t rdat;
      logic            err;
      begin_test("round_trip");
      for (int i = 0; i < row_len; i++) src[i] = mem_word(32'h100 + 4 * i);
      run_op(make_inst(nice_pkg::funct7_lbuf, nice_pkg::funct3_buf), 32'h100, 0, rdat, err);
      check_word("lbuf rsp_rdat", '0, rdat);
      check_bit("lbuf rsp_err", 1'b0, err);
      run_op(make_inst(nice_pkg::funct7_sbuf, nice_pkg::funct3_buf), 32'h180, 0, rdat, err);
      check_word("sbuf rsp_rdat", '0, rdat);
      check_bit("sbuf rsp_err", 1'b0, err);
      for (int i = 0; i < row_len; i++) begin
         check_word($sformatf("stored word %0d", i), src[i], mem_word(32'h180 + 4 * i));
      end
      end_test();
   endtask

   task automatic test_row_sum();
      nice_pkg::word_t src [row_len];
      nice_pkg::word_t col [row_len];
      nice_pkg::word_t sum;
      nice_pkg::word_t rdat;
      logic            err;
      begin_test("row_sum");
      sum = '0;
      for (int i = 0; i < row_len; i++) begin
         src[i] = mem_word(32'h040 + 4 * i);
         col[i] = mem_word(32'h200 + 4 * i);
         sum    = sum + col[i];
      end
      run_op(make_inst(nice_pkg::funct7_lbuf, nice_pkg::funct3_buf), 32'h040, 0, rdat, err);
      run_op(make_inst(nice_pkg::funct7_rowsum, nice_pkg::funct3_rowsum), 32'h200, 0,
             rdat, err);
      check_word("rowsum rsp_rdat", sum, rdat);
      check_bit("rowsum rsp_err", 1'b0, err);
      // buffer now holds loaded word plus column word
      run_op(make_inst(nice_pkg::funct7_sbuf, nice_pkg::funct3_buf), 32'h280, 0, rdat, err);
      // sum is nonzero now, so rd must still read back as zero
      check_word("sbuf rsp_rdat", '0, rdat);
      for (int i = 0; i < row_len; i++) begin
         check_word($sformatf("column %0d", i), src[i] + col[i], mem_word(32'h280 + 4 * i));
      end
      end_test();
   endtask

   task automatic test_addressing();
      nice_pkg::word_t rdat;
      logic            err;
      begin_test("addressing");
      mon_addr.delete();
      mon_read.delete();
      mon_size.delete();
      run_op(make_inst(nice_pkg::funct7_lbuf, nice_pkg::funct3_buf), 32'h0c0, 0, rdat, err);
      run_op(make_inst(nice_pkg::funct7_sbuf, nice_pkg::funct3_buf), 32'h140, 0, rdat, err);
      check_word("command count", 2 * row_len, nice_pkg::word_t'(mon_addr.size()));
      for (int i = 0; i < mon_addr.size() && i < 2 * row_len; i++) begin
         // first row is the lbuf, second the sbuf
         check_word($sformatf("addr %0d", i),
                    (i < row_len ? 32'h0c0 : 32'h140 - 4 * row_len) + 4 * i, mon_addr[i]);
         check_bit($sformatf("read %0d", i), i < row_len, mon_read[i]);
         check_word($sformatf("size %0d", i), nice_pkg::word_t'(nice_pkg::size_word),
                    nice_pkg::word_t'(mon_size[i]));
      end
      end_test();
   endtask

   task automatic test_backpressure();
      nice_pkg::word_t sum;
      nice_pkg::word_t rdat;
      logic            err;
      begin_test("backpressure");
      sum = '0;
      for (int i = 0; i < row_len; i++) sum = sum + mem_word(32'h200 + 4 * i);
      run_op(make_inst(nice_pkg::funct7_rowsum, nice_pkg::funct3_rowsum), 32'h200, 10,
             rdat, err);
      check_word("rowsum rsp_rdat", sum, rdat);
      @(posedge nice_clk);
      check_bit("mem_holdup after handshake", 1'b0, mem_holdup);
      #2;
      end_test();
   endtask

   task automatic test_unsupported();
      int cmds_before;
      begin_test("unsupported");
      cmds_before = mon_count;
      req_inst  = make_inst(7'h7f, nice_pkg::funct3_buf);
      req_rs1   = 32'h100;
      req_valid = 1'b1;
      do @(posedge nice_clk); while (!req_ready);
      // idle with a request pending
      check_bit("active with request", 1'b1, active);
      #2 req_valid = 1'b0;
      // ignored op: nothing may happen afterwards
      repeat (10) begin
         @(posedge nice_clk);
         check_bit("rsp_valid", 1'b0, rsp_valid);
         check_bit("mem_holdup", 1'b0, mem_holdup);
         check_bit("active", 1'b0, active);
      end
      check_word("command count", cmds_before, mon_count);
      #2;
      end_test();
   endtask

   task automatic test_bus_error();
      nice_pkg::word_t rdat;
      logic            err;
      begin_test("bus_error");
      // second word of this row is the error address
      run_op(make_inst(nice_pkg::funct7_lbuf, nice_pkg::funct3_buf), err_addr - 4, 0,
             rdat, err);
      check_bit("rsp_err on error row", 1'b1, err);
      run_op(make_inst(nice_pkg::funct7_lbuf, nice_pkg::funct3_buf), 32'h340, 0, rdat, err);
      check_bit("rsp_err on clean row", 1'b0, err);
      end_test();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      reset     = 1'b1;
      req_valid = 1'b0;
      req_inst  = '0;
      req_rs1   = '0;
      req_rs2   = '0;
      rsp_ready = 1'b1;
      repeat (8) @(posedge nice_clk);
      #2 reset = 1'b0;
      test_round_trip();
      test_row_sum();
      test_addressing();
      test_backpressure();
      test_unsupported();
      test_bus_error();
      $display("%0d tests, %0d with errors, %0d checks, %0d errors",
               tests_run, tests_failed, checks, total_errors);
      if (total_errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* flist.f */
source/nice_pkg.sv
source/nice_rowbuf_if.sv
source/nice_ctrl_fsm.sv
source/nice_beat_counter.sv
source/nice_lsu.sv
source/nice_rowbuf.sv
source/nice_core.sv
verif/nice_mem_model.sv
verif/nice_core_tb.sv
